// File: bench/bru_vectors.txt
// op pc pred_pc imm a_src a_val a_dly b_src b_val b_dly wb_v wb_data rs_v rs_pc taken misp
// src 0 unneeded, 1 forward, 2 register read after dly cycles in OC
1 1000 1010 10 0 0 0 0 0 0 1 1004 1 1010 1 0
1 2000 2004 FFFFFFF0 0 0 0 0 0 0 1 2004 1 1FF0 1 1
0 3000 5008 8 1 5000 0 0 0 0 1 3004 1 5008 1 0
0 3100 3104 FFFFFFFC 2 6000 3 0 0 0 1 3104 1 5FFC 1 1
4 4000 4004 12000 0 0 0 0 0 0 1 16000 0 0 0 0
8 5000 5040 40 1 7 0 1 7 0 0 0 1 5040 1 0
8 5100 5140 40 2 7 0 2 8 2 0 0 1 5104 0 1
9 5200 5204 20 1 1 0 2 2 4 0 0 1 5220 1 1
9 5300 5304 20 2 9 2 1 9 0 0 0 1 5304 0 0
C 6000 5F00 FFFFFF00 1 FFFFFFFF 0 1 1 0 0 0 1 5F00 1 0
C 6100 6104 80 2 1 1 2 FFFFFFFF 1 0 0 1 6104 0 0
D 6200 6204 80 2 FFFFFFFF 0 1 1 0 0 0 1 6204 0 0
D 6300 6304 80 1 5 0 2 5 3 0 0 1 6380 1 1
E 7000 7004 100 1 FFFFFFFF 0 1 1 0 0 0 1 7004 0 0
E 7100 7104 100 2 1 2 2 FFFFFFFF 0 0 0 1 7200 1 1
F 7200 7300 100 1 FFFFFFFF 0 1 1 0 0 0 1 7300 1 0
F 7300 7400 100 2 3 1 1 4 0 0 0 1 7304 0 1
8 8000 8004 FFFFFFF0 1 FFFFFFFF 0 2 1 0 0 0 1 8004 0 0
9 8100 80F0 FFFFFFF0 2 ABCD 5 2 ABCD 1 0 0 1 8104 0 1
0 9000 A000 FFFFFFFE 2 A002 0 0 0 0 1 9004 1 A000 1 0
4 9100 9104 FFFFF000 0 0 0 0 0 0 1 8100 0 0 0 0
E 9200 9204 40 2 0 0 2 0 0 0 0 1 9204 0 0

// File: all.f
common/bru_pkg.sv
bru/bru_operand_collect.sv
bru/bru_resolve.sv
bru/bru_result_regs.sv
bru/bru_pipeline.sv
bench/bru_pipeline_asserts.sv
bench/bru_tb.sv

// File: Bender.yml
package:
  name: bru

sources:
  - common/bru_pkg.sv
  - bru/bru_operand_collect.sv
  - bru/bru_resolve.sv
  - bru/bru_result_regs.sv
  - bru/bru_pipeline.sv
  - target: simulation
    files:
      - bench/bru_pipeline_asserts.sv
      - bench/bru_tb.sv

// File: bench/bru_tb.sv
// Testbench that replays the vector file against bru_pipeline with a register file model
module bru_tb;

    // One vector line with the fields in file order
    typedef struct packed {
        bru_pkg::word_t op;
        bru_pkg::word_t pc;
        bru_pkg::word_t pred_pc;
        bru_pkg::word_t imm;
        bru_pkg::word_t a_src;
        bru_pkg::word_t a_val;
        bru_pkg::word_t a_dly;
        bru_pkg::word_t b_src;
        bru_pkg::word_t b_val;
        bru_pkg::word_t b_dly;
        bru_pkg::word_t wb_valid;
        bru_pkg::word_t wb_data;
        bru_pkg::word_t rs_valid;
        bru_pkg::word_t rs_pc;
        bru_pkg::word_t rs_taken;
        bru_pkg::word_t rs_mispredict;
    } vector_t;

    logic                         CLK;
    logic                         nRST;
    logic                         issue_valid;
    bru_pkg::bru_issue_t          issue;
    logic                         issue_ready;
    bru_pkg::bru_read_ack_t       a_read;
    bru_pkg::bru_read_ack_t       b_read;
    bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0][bru_pkg::PRF_READ_PORTS-1:0] read_data;
    bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0] forward_data;
    logic                         wb_valid;
    bru_pkg::bru_wb_t             wb;
    logic                         wb_ready;
    logic                         restart_valid;
    bru_pkg::bru_restart_t        restart;
    logic                         restart_ready;

    bru_pkg::word_t raw [0:1023];
    vector_t        vecs [0:63];
    int             accept_cycle [0:63];
    int             num_vec;
    int             wb_q[$];
    int             rs_q[$];
    int             cycle = 0;
    int             phase;
    logic           bp_mode;
    logic [31:0]    lcg_state;

    bru_pipeline u_bru_pipeline (.*);

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    // ------------------------------------------------------------------
    // Helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_value(input string name, input bru_pkg::word_t got,
                               input bru_pkg::word_t exp);
        assert (got === exp) else begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_vectors();
        vector_t v;
        // Words the file does not reach keep an op field wider than 4 bits
        for (int k = 0; k < 1024; k++) begin
            raw[k] = 32'hFFFF_0000 | k;
        end
        $readmemh("bench/bru_vectors.txt", raw);
        num_vec = 0;
        while (num_vec < 64 && raw[16 * num_vec][31:4] == '0) begin
            for (int f = 0; f < 16; f++) begin
                v[(15 - f) * 32 +: 32] = raw[16 * num_vec + f];
            end
            vecs[num_vec] = v;
            num_vec++;
        end
        assert (num_vec > 0)
            else report_error("no vectors could be read from the vector file");
    endtask

    // Operand A sits in bank i%4 and operand B two banks further on
    function automatic bru_pkg::bru_issue_t make_issue(input int i);
        bru_pkg::bru_issue_t req;
        vector_t             v;
        v                     = vecs[i];
        req.op                = bru_pkg::bru_op_e'(v.op[3:0]);
        req.pc                = v.pc;
        req.pred_pc           = v.pred_pc;
        req.imm               = v.imm;
        req.a_src.unneeded    = v.a_src == 0;
        req.a_src.forward     = v.a_src == 1;
        req.a_src.bank        = bru_pkg::bank_t'(i % 4);
        req.b_src.unneeded    = v.b_src == 0;
        req.b_src.forward     = v.b_src == 1;
        req.b_src.bank        = bru_pkg::bank_t'((i + 2) % 4);
        req.dest_pr           = bru_pkg::pr_t'(i * 7 + 1);
        req.rob_index         = bru_pkg::rob_index_t'(phase * 32 + i);
        return req;
    endfunction

    function automatic logic zero_delay(input int i);
        return (vecs[i].a_src != 2 || vecs[i].a_dly == 0) &&
               (vecs[i].b_src != 2 || vecs[i].b_dly == 0);
    endfunction

    // Register file model for the op sitting in OC
    task automatic drive_operands(input int cur, input int cyc);
        vector_t v;
        forward_data = '0;
        read_data    = '0;
        a_read       = '0;
        b_read       = '0;
        if (cur >= 0) begin
            v = vecs[cur];
            if (v.a_src == 1 && cyc == 0) forward_data[cur % 4] = v.a_val;
            if (v.b_src == 1 && cyc == 0) forward_data[(cur + 2) % 4] = v.b_val;
            if (v.a_src == 2 && cyc == v.a_dly) begin
                a_read.ack                       = 1'b1;
                a_read.port                      = cur % 2;
                read_data[cur % 4][cur % 2]      = v.a_val;
            end
            if (v.b_src == 2 && cyc == v.b_dly) begin
                b_read.ack                             = 1'b1;
                b_read.port                            = (cur + 1) % 2;
                read_data[(cur + 2) % 4][(cur + 1) % 2] = v.b_val;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Issue side with ops sent back to back

    task automatic drive_phase();
        int   cur;
        int   cyc;
        int   nxt;
        int   idle;
        logic launched;
        logic accepted;
        cur  = -1;
        cyc  = 0;
        nxt  = 0;
        idle = 0;
        @(posedge CLK);
        #1;
        while (nxt < num_vec || cur >= 0) begin
            drive_operands(cur, cyc);
            issue_valid = nxt < num_vec;
            if (nxt < num_vec) issue = make_issue(nxt);
            @(negedge CLK);
            // Ready while holding an op means OC launches at this edge
            launched = cur >= 0 && issue_ready;
            accepted = issue_valid && issue_ready;
            if (accepted) accept_cycle[nxt] = cycle + 1;
            @(posedge CLK);
            #1;
            if (launched) cur = -1;
            if (accepted) begin
                cur  = nxt;
                cyc  = 0;
                idle = 0;
                nxt++;
            end else begin
                cyc++;
                idle++;
            end
            assert (idle < 100)
                else report_error("timeout waiting for the pipeline to take an op");
        end
        issue_valid = 1'b0;
        drive_operands(-1, 0);
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (wb_q.size() > 0 || rs_q.size() > 0) begin
            @(posedge CLK);
            waited++;
            assert (waited < 200) else report_error("timeout waiting for the expected results");
        end
        // Quiet cycles so that a duplicate result would still show up
        repeat (4) @(posedge CLK);
    endtask

    task automatic run_phase(input int p, input logic bp);
        phase   = p;
        bp_mode = bp;
        for (int i = 0; i < num_vec; i++) begin
            if (vecs[i].wb_valid != 0) wb_q.push_back(i);
            if (vecs[i].rs_valid != 0) rs_q.push_back(i);
        end
        drive_phase();
        drain_outputs();
        bp_mode = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Output side

    always @(posedge CLK) begin
        #1;
        if (bp_mode) begin
            lcg_state     = lcg_next(lcg_state);
            wb_ready      = lcg_state[17:16] != 2'b00;
            lcg_state     = lcg_next(lcg_state);
            restart_ready = lcg_state[17:16] != 2'b00;
        end else begin
            wb_ready      = 1'b1;
            restart_ready = 1'b1;
        end
    end

    task automatic check_wb();
        int i;
        assert (wb_q.size() > 0)
            else report_error("a writeback appeared that no op should produce");
        i = wb_q.pop_front();
        check_value("wb.data", wb.data, vecs[i].wb_data);
        check_value("wb.pr", wb.pr, (i * 7 + 1) % 64);
        check_value("wb.rob_index", wb.rob_index, (phase * 32 + i) % 64);
        if (!bp_mode && zero_delay(i)) begin
            check_value("wb_valid latency", cycle - accept_cycle[i], 2);
        end
    endtask

    task automatic check_restart();
        int i;
        assert (rs_q.size() > 0)
            else report_error("a restart appeared that no op should produce");
        i = rs_q.pop_front();
        check_value("restart.pc", restart.pc, vecs[i].rs_pc);
        check_value("restart.taken", restart.taken, vecs[i].rs_taken);
        check_value("restart.mispredict", restart.mispredict, vecs[i].rs_mispredict);
        check_value("restart.rob_index", restart.rob_index, (phase * 32 + i) % 64);
        if (!bp_mode && zero_delay(i)) begin
            check_value("restart_valid latency", cycle - accept_cycle[i], 2);
        end
    endtask

    always @(negedge CLK) begin
        if (nRST === 1'b1) begin
            assert (u_bru_pipeline.u_asserts.fail_count == 0)
                else report_error("a bound protocol assertion failed");
            if (wb_valid && wb_ready) check_wb();
            if (restart_valid && restart_ready) check_restart();
        end
    end

    // ------------------------------------------------------------------
    // Sequence

    initial begin
        CLK           = 1'b0;
        nRST          = 1'b1;
        issue_valid   = 1'b0;
        issue         = '0;
        a_read        = '0;
        b_read        = '0;
        read_data     = '0;
        forward_data  = '0;
        wb_ready      = 1'b1;
        restart_ready = 1'b1;
        bp_mode       = 1'b0;
        phase         = 0;
        lcg_state     = 32'd1;
        load_vectors();
        #1 nRST = 1'b0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;
        // Readies held high and latency checked on zero-delay ops
        run_phase(0, 1'b0);
        // Random back-pressure on both output channels
        run_phase(1, 1'b1);
        if (u_bru_pipeline.u_asserts.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "bound assertions reported errors");
        end
    end

endmodule

// File: bench/bru_pipeline_asserts.sv
// Concurrent protocol checks on the branch unit output channels, bound into bru_pipeline
module bru_pipeline_asserts (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  issue_ready,
    input logic                  ex_valid,
    input logic                  ex_q_valid,
    input bru_pkg::bru_op_e      ex_q_op,
    input logic                  advance,
    input logic                  wb_valid,
    input bru_pkg::bru_wb_t      wb,
    input logic                  wb_ready,
    input logic                  restart_valid,
    input bru_pkg::bru_restart_t restart,
    input logic                  restart_ready
);

    int fail_count = 0;

    // ------------------------------------------------------------------
    // Output channels hold until taken

    wb_held: assert property (@(posedge CLK) disable iff (!nRST)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb))
        else begin
            $error("writeback dropped or changed while stalled");
            fail_count++;
        end

    restart_held: assert property (@(posedge CLK) disable iff (!nRST)
        restart_valid && !restart_ready |=> restart_valid && $stable(restart))
        else begin
            $error("restart dropped or changed while stalled");
            fail_count++;
        end

    // Conditional branches have bit 3 of the op set
    branch_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
        ex_q_valid && ex_q_op[3] && advance |=> !wb_valid)
        else begin
            $error("conditional branch produced a writeback");
            fail_count++;
        end

    reset_idle: assert property (@(posedge CLK)
        !nRST |-> issue_ready && !ex_valid && !ex_q_valid && !wb_valid && !restart_valid)
        else begin
            $error("pipeline not idle during reset");
            fail_count++;
        end

endmodule

bind bru_pipeline bru_pipeline_asserts u_asserts (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue_ready   (issue_ready),
    .ex_valid      (ex_valid),
    .ex_q_valid    (u_resolve.ex_q_valid),
    .ex_q_op       (u_resolve.ex_q.op),
    .advance       (advance),
    .wb_valid      (wb_valid),
    .wb            (wb),
    .wb_ready      (wb_ready),
    .restart_valid (restart_valid),
    .restart       (restart),
    .restart_ready (restart_ready)
);

// File: bru/bru_pipeline.sv
// Top of the branch resolution unit, chains operand collect, execute and writeback stages
module bru_pipeline (
    input  logic                  CLK,
    input  logic                  nRST,

    // Issue
    input  logic                  issue_valid,
    input  bru_pkg::bru_issue_t   issue,
    output logic                  issue_ready,

    // Register reads
    input  bru_pkg::bru_read_ack_t a_read,
    input  bru_pkg::bru_read_ack_t b_read,
    input  bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0][bru_pkg::PRF_READ_PORTS-1:0] read_data,

    // Forwarding
    input  bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0] forward_data,

    // Writeback
    output logic                  wb_valid,
    output bru_pkg::bru_wb_t      wb,
    input  logic                  wb_ready,

    // Restart
    output logic                  restart_valid,
    output bru_pkg::bru_restart_t restart,
    input  logic                  restart_ready
);

    // ------------------------------------------------------------------
    // Stage handoffs

    logic                  ex_valid;
    bru_pkg::bru_ex_t      ex;
    logic                  ex_ready;
    logic                  next_wb_valid;
    bru_pkg::bru_wb_t      next_wb;
    logic                  next_restart_valid;
    bru_pkg::bru_restart_t next_restart;
    logic                  advance;

    bru_operand_collect u_operand_collect (
        .CLK          (CLK),
        .nRST         (nRST),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .a_read       (a_read),
        .b_read       (b_read),
        .read_data    (read_data),
        .forward_data (forward_data),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .ex_ready     (ex_ready)
    );

    bru_resolve u_resolve (
        .CLK                (CLK),
        .nRST               (nRST),
        .ex_valid           (ex_valid),
        .ex                 (ex),
        .ex_ready           (ex_ready),
        .advance            (advance),
        .next_wb_valid      (next_wb_valid),
        .next_wb            (next_wb),
        .next_restart_valid (next_restart_valid),
        .next_restart       (next_restart)
    );

    bru_result_regs u_result_regs (
        .CLK                (CLK),
        .nRST               (nRST),
        .next_wb_valid      (next_wb_valid),
        .next_wb            (next_wb),
        .next_restart_valid (next_restart_valid),
        .next_restart       (next_restart),
        .advance            (advance),
        .wb_valid           (wb_valid),
        .wb                 (wb),
        .wb_ready           (wb_ready),
        .restart_valid      (restart_valid),
        .restart            (restart),
        .restart_ready      (restart_ready)
    );

endmodule

// File: bru/bru_result_regs.sv
// Writeback stage registers, one for the register writeback channel and one for ROB restarts
module bru_result_regs (
    input  logic                  CLK,
    input  logic                  nRST,

    // Results from EX
    input  logic                  next_wb_valid,
    input  bru_pkg::bru_wb_t      next_wb,
    input  logic                  next_restart_valid,
    input  bru_pkg::bru_restart_t next_restart,
    output logic                  advance,

    // Register writeback channel
    output logic                  wb_valid,
    output bru_pkg::bru_wb_t      wb,
    input  logic                  wb_ready,

    // Restart channel to the ROB
    output logic                  restart_valid,
    output bru_pkg::bru_restart_t restart,
    input  logic                  restart_ready
);

    logic wb_blocked;
    logic restart_blocked;

    // A channel blocks only while it holds an item not yet taken
    assign wb_blocked      = wb_valid & ~wb_ready;
    assign restart_blocked = restart_valid & ~restart_ready;
    assign advance         = ~(wb_blocked | restart_blocked);

    // ------------------------------------------------------------------
    // Valid bits

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_valid      <= 1'b0;
            restart_valid <= 1'b0;
        end else if (advance) begin
            wb_valid      <= next_wb_valid;
            restart_valid <= next_restart_valid;
        end else begin
            // The channel that was accepted clears while the other one waits
            wb_valid      <= wb_blocked;
            restart_valid <= restart_blocked;
        end
    end

    // ------------------------------------------------------------------
    // Payloads, stable whenever the stage is stalled

    always_ff @(posedge CLK) begin
        if (advance) begin
            wb      <= next_wb;
            restart <= next_restart;
        end
    end

endmodule

// File: bru/bru_resolve.sv
// Execute stage, resolves jumps, AUIPC and conditional branches into writeback and restart results
module bru_resolve (
    input  logic                  CLK,
    input  logic                  nRST,

    // From OC
    input  logic                  ex_valid,
    input  bru_pkg::bru_ex_t      ex,
    output logic                  ex_ready,

    // To the WB registers
    input  logic                  advance,
    output logic                  next_wb_valid,
    output bru_pkg::bru_wb_t      next_wb,
    output logic                  next_restart_valid,
    output bru_pkg::bru_restart_t next_restart
);

    // ------------------------------------------------------------------
    // EX register

    logic             ex_q_valid;
    bru_pkg::bru_ex_t ex_q;

    assign ex_ready = ~ex_q_valid | advance;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_q_valid <= 1'b0;
        end else if (ex_ready) begin
            ex_q_valid <= ex_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_ready) begin
            ex_q <= ex;
        end
    end

    // ------------------------------------------------------------------
    // Address arithmetic

    bru_pkg::word_t pc_plus_4;
    bru_pkg::word_t pc_plus_imm;
    bru_pkg::word_t a_plus_imm;
    bru_pkg::word_t true_next_pc;
    logic           taken;
    logic           is_jalr;
    logic           writes;
    logic           restarts;

    assign pc_plus_4   = ex_q.pc + 32'd4;
    assign pc_plus_imm = ex_q.pc + ex_q.imm;
    assign a_plus_imm  = ex_q.a + ex_q.imm;

    // ------------------------------------------------------------------
    // Per-op condition and result kind

    always_comb begin
        taken    = 1'b0;
        is_jalr  = 1'b0;
        writes   = 1'b0;
        restarts = 1'b0;
        case (ex_q.op)
            bru_pkg::BRU_JALR: begin
                taken    = 1'b1;
                is_jalr  = 1'b1;
                writes   = 1'b1;
                restarts = 1'b1;
            end
            bru_pkg::BRU_JAL: begin
                taken    = 1'b1;
                writes   = 1'b1;
                restarts = 1'b1;
            end
            // AUIPC writes a register but never redirects fetch
            bru_pkg::BRU_AUIPC: begin
                taken  = 1'b1;
                writes = 1'b1;
            end
            bru_pkg::BRU_BEQ: begin
                taken    = ex_q.a == ex_q.b;
                restarts = 1'b1;
            end
            bru_pkg::BRU_BNE: begin
                taken    = ex_q.a != ex_q.b;
                restarts = 1'b1;
            end
            bru_pkg::BRU_BLT: begin
                taken    = $signed(ex_q.a) < $signed(ex_q.b);
                restarts = 1'b1;
            end
            bru_pkg::BRU_BGE: begin
                taken    = $signed(ex_q.a) >= $signed(ex_q.b);
                restarts = 1'b1;
            end
            bru_pkg::BRU_BLTU: begin
                taken    = ex_q.a < ex_q.b;
                restarts = 1'b1;
            end
            bru_pkg::BRU_BGEU: begin
                taken    = ex_q.a >= ex_q.b;
                restarts = 1'b1;
            end
            default: begin
                // Undefined codes are dropped
                taken = 1'b0;
            end
        endcase
    end

    // JALR goes through a register, everything else is PC relative
    assign true_next_pc = is_jalr ? a_plus_imm : (taken ? pc_plus_imm : pc_plus_4);

    // ------------------------------------------------------------------
    // Results

    assign next_wb_valid      = ex_q_valid & writes;
    assign next_wb.data       = (ex_q.op == bru_pkg::BRU_AUIPC) ? pc_plus_imm : pc_plus_4;
    assign next_wb.pr         = ex_q.dest_pr;
    assign next_wb.rob_index  = ex_q.rob_index;

    assign next_restart_valid      = ex_q_valid & restarts;
    assign next_restart.mispredict = ex_q.pred_pc != true_next_pc;
    assign next_restart.rob_index  = ex_q.rob_index;
    assign next_restart.pc         = true_next_pc;
    assign next_restart.taken      = taken;

endmodule

// File: bru/bru_operand_collect.sv
// Operand collect stage, holds one issued op until both operands are present and EX accepts it
module bru_operand_collect (
    input  logic                  CLK,
    input  logic                  nRST,

    // Issue from the branch issue queue
    input  logic                  issue_valid,
    input  bru_pkg::bru_issue_t   issue,
    output logic                  issue_ready,

    // Register file read acknowledgments and data
    input  bru_pkg::bru_read_ack_t a_read,
    input  bru_pkg::bru_read_ack_t b_read,
    input  bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0][bru_pkg::PRF_READ_PORTS-1:0] read_data,

    // Forwarded data, one word per bank
    input  bru_pkg::word_t [bru_pkg::PRF_BANK_COUNT-1:0] forward_data,

    // Handoff to EX
    output logic                  ex_valid,
    output bru_pkg::bru_ex_t      ex,
    input  logic                  ex_ready
);

    // ------------------------------------------------------------------
    // Stage state

    logic                res_valid;
    bru_pkg::bru_issue_t issue_q;

    // Index 0 is operand A, index 1 is operand B
    logic [1:0]                     saved_q;
    logic [1:0]                     fwd_q;
    bru_pkg::word_t [1:0]           saved_data;
    bru_pkg::bru_operand_src_t [1:0] src;
    bru_pkg::bru_read_ack_t [1:0]   ack;
    bru_pkg::word_t [1:0]           opnd;
    logic [1:0]                     present;
    logic                           launch;

    assign src = {issue_q.b_src, issue_q.a_src};
    assign ack = {b_read, a_read};

    // ------------------------------------------------------------------
    // Operand selection

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            present[i] = src[i].unneeded | saved_q[i] | fwd_q[i] | ack[i].ack;
            if (saved_q[i]) begin
                opnd[i] = saved_data[i];
            end else if (fwd_q[i]) begin
                opnd[i] = forward_data[src[i].bank];
            end else begin
                opnd[i] = read_data[src[i].bank][ack[i].port];
            end
        end
    end

    assign ex_valid    = res_valid & (&present);
    assign launch      = ex_valid & ex_ready;
    assign issue_ready = ~res_valid | launch;

    // ------------------------------------------------------------------
    // Control registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            res_valid <= 1'b0;
            saved_q   <= 2'b00;
            fwd_q     <= 2'b00;
        end else if (issue_ready) begin
            // Empty or launching, so take whatever the issue side offers
            res_valid <= issue_valid;
            saved_q   <= 2'b00;
            fwd_q[0]  <= issue_valid & issue.a_src.forward;
            fwd_q[1]  <= issue_valid & issue.b_src.forward;
        end else begin
            // Forward data is only on the bus in the first cycle
            for (int i = 0; i < 2; i++) begin
                saved_q[i] <= saved_q[i] | fwd_q[i] | ack[i].ack;
            end
            fwd_q <= 2'b00;
        end
    end

    // ------------------------------------------------------------------
    // Payload registers

    always_ff @(posedge CLK) begin
        if (issue_ready) begin
            issue_q <= issue;
        end
        for (int i = 0; i < 2; i++) begin
            // Capture once, then keep the value until launch
            if (!saved_q[i] && (fwd_q[i] || ack[i].ack)) begin
                saved_data[i] <= opnd[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // EX payload

    always_comb begin
        ex.op        = issue_q.op;
        ex.pc        = issue_q.pc;
        ex.pred_pc   = issue_q.pred_pc;
        ex.imm       = issue_q.imm;
        ex.a         = opnd[0];
        ex.b         = opnd[1];
        ex.dest_pr   = issue_q.dest_pr;
        ex.rob_index = issue_q.rob_index;
    end

endmodule

// File: common/bru_pkg.sv
// Shared widths, types and stage payload structs for the branch resolution unit and its testbench
package bru_pkg;

    // ------------------------------------------------------------------
    // Sizes of the surrounding core

    localparam int PRF_BANK_COUNT     = 4;
    localparam int LOG_PRF_BANK_COUNT = 2;
    localparam int PRF_READ_PORTS     = 2;
    localparam int LOG_PR_COUNT       = 6;
    localparam int LOG_ROB_ENTRIES    = 6;

    // ------------------------------------------------------------------
    // Basic types

    typedef logic [31:0]                   word_t;
    typedef logic [LOG_PR_COUNT-1:0]       pr_t;
    typedef logic [LOG_ROB_ENTRIES-1:0]    rob_index_t;
    typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;

    // Op codes as sent by the issue queue
    typedef enum logic [3:0] {
        BRU_JALR  = 4'b0000,
        BRU_JAL   = 4'b0001,
        BRU_AUIPC = 4'b0100,
        BRU_BEQ   = 4'b1000,
        BRU_BNE   = 4'b1001,
        BRU_BLT   = 4'b1100,
        BRU_BGE   = 4'b1101,
        BRU_BLTU  = 4'b1110,
        BRU_BGEU  = 4'b1111
    } bru_op_e;

    // ------------------------------------------------------------------
    // Stage payloads

    // Where an operand will come from
    typedef struct packed {
        logic  unneeded;
        logic  forward;
        bank_t bank;
    } bru_operand_src_t;

    typedef struct packed {
        bru_op_e          op;
        word_t            pc;
        word_t            pred_pc;
        word_t            imm;
        bru_operand_src_t a_src;
        bru_operand_src_t b_src;
        pr_t              dest_pr;
        rob_index_t       rob_index;
    } bru_issue_t;

    typedef struct packed {
        bru_op_e    op;
        word_t      pc;
        word_t      pred_pc;
        word_t      imm;
        word_t      a;
        word_t      b;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } bru_ex_t;

    typedef struct packed {
        word_t      data;
        pr_t        pr;
        rob_index_t rob_index;
    } bru_wb_t;

    typedef struct packed {
        logic       mispredict;
        rob_index_t rob_index;
        word_t      pc;
        logic       taken;
    } bru_restart_t;

    // Register read acknowledgment for one operand
    typedef struct packed {
        logic                              ack;
        logic [$clog2(PRF_READ_PORTS)-1:0] port;
    } bru_read_ack_t;

endpackage
